//--- Makefile
VERILATOR = verilator
VFLAGS    = --binary --timing -Wno-fatal -j 0
TOP       = tbBundlePredecode
FILELIST  = project.f
OBJDIR    = obj_dir

SRCS := $(shell grep -v '^+' $(FILELIST))
BIN  := $(OBJDIR)/V$(TOP)

.PHONY: all run clean

all: $(BIN)

$(BIN): $(SRCS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJDIR) -f $(FILELIST)

run: $(BIN)
	@out="$$(./$(BIN))"; echo "$$out"; echo "$$out" | grep -qx "Simulation PASSED"

clean:
	rm -rf $(OBJDIR)

//--- boundaryScan.sv
// *********************************************************************
// boundary scan
// finds instruction start parcels from the stop vector and start
// offset, measures lengths and flags over-long or unterminated runs
// *********************************************************************
`timescale 1ns/1ps
`default_nettype none

module boundaryScan import predecodePkg::*; (
  input  logic [numParcels-1:0]           heldStop,
  input  logic [offW-1:0]                 heldOff,
  output logic [numParcels-1:0]           isStart,
  output logic [numParcels-1:0][lenW-1:0] len,
  output logic                            malformed
);

  logic [numParcels-1:0]          prevStop;
  logic [numParcels+maxLen-2:0]   stopExt;

  // stop of the parcel before, parcel 0 has none
  assign prevStop = {heldStop[numParcels-2:0], 1'b0};

  // zero padding past parcel 15 reads as no stop
  assign stopExt = {{(maxLen-1){1'b0}}, heldStop};

  always_comb begin
    logic cand;
    logic found;

    isStart   = '0;
    len       = '0;
    malformed = 1'b0;
    for (int i = 0; i < numParcels; i++) begin
      cand = (i == int'(heldOff)) || ((i > int'(heldOff)) && prevStop[i]);
      found = 1'b0;
      // search downwards so the nearest stop wins
      for (int k = maxLen - 1; k >= 0; k--) begin
        if (stopExt[i+k]) begin
          found  = 1'b1;
          len[i] = lenW'(k + 1);
        end
      end
      if (cand && found)
        isStart[i] = 1'b1;
      else if (cand)
        malformed = 1'b1;   // longer than maxLen or no stop at all
    end
  end

endmodule

`default_nettype wire

//--- bundleCapture.sv
// *********************************************************************
// bundle capture
// input side of the predecoder, holds one bundle with its stop
// vector and start offset under a four-phase req/ack handshake
// *********************************************************************
`timescale 1ns/1ps
`default_nettype none

module bundleCapture import predecodePkg::*; (
  input  logic                  clk,
  input  logic                  rstN,
  input  logic [bundleW-1:0]    bundle,
  input  logic [numParcels-1:0] stopBits,
  input  logic [offW-1:0]       startOff,
  input  logic                  bundleReq,
  input  logic                  take,
  output logic                  bundleAck,
  output logic [bundleW-1:0]    heldBundle,
  output logic [numParcels-1:0] heldStop,
  output logic [offW-1:0]       heldOff,
  output logic                  full
);

  logic load;

  // new request, previous one retired and a free register
  assign load = bundleReq && !bundleAck && !full;

  always_ff @(posedge clk) begin
    if (!rstN) begin
      full      <= 1'b0;
      bundleAck <= 1'b0;
    end else if (load) begin
      full      <= 1'b1;
      bundleAck <= 1'b1;
    end else begin
      if (take)
        full <= 1'b0;          // result stage took it
      if (bundleAck && !bundleReq)
        bundleAck <= 1'b0;     // return to zero
    end
  end

  always_ff @(posedge clk) begin
    if (load) begin
      heldBundle <= bundle;
      heldStop   <= stopBits;
      heldOff    <= startOff;
    end
  end

endmodule

`default_nettype wire

//--- bundlePredecode.sv
// *********************************************************************
// bundle predecoder top level
// capture, boundary scan, per-parcel classifiers, instruction and
// jump compaction and the registered result stage
// *********************************************************************
`timescale 1ns/1ps
`default_nettype none

module bundlePredecode import predecodePkg::*; #(
  parameter int maxInstr = 8,
  parameter int maxJumps = 4
) (
  input  logic                        clk,
  input  logic                        rstN,
  input  logic [bundleW-1:0]          bundle,
  input  logic [numParcels-1:0]       stopBits,
  input  logic [offW-1:0]             startOff,
  input  logic                        bundleReq,
  input  logic                        outAck,
  output logic                        bundleAck,
  output logic                        outReq,
  output instrSlot_t [maxInstr-1:0]   instrSlots,
  output logic [maxInstr-1:0]         instrEn,
  output jumpSlot_t [maxJumps-1:0]    jumpSlots,
  output logic [maxJumps-1:0]         jumpEn,
  output logic                        overflow,
  output logic                        jumpOverflow,
  output logic                        malformed
);

  logic [bundleW-1:0]                   heldBundle;
  logic [numParcels-1:0]                heldStop;
  logic [offW-1:0]                      heldOff;
  logic                                 full;
  logic                                 take;
  logic [numParcels-1:0]                isStart;
  logic [numParcels-1:0][lenW-1:0]      len;
  logic                                 scanMalformed;
  instrClass_t [numParcels-1:0]         cls;
  logic [bundleW+instrW-parcelW-1:0]    paddedBundle;
  instrSlot_t [numParcels-1:0]          instrEntry;
  logic [numParcels-1:0][offW-1:0]      instrIdx;
  logic [numParcels-1:0]                jumpValid;
  jumpSlot_t [numParcels-1:0]           jumpEntry;
  instrSlot_t [maxInstr-1:0]            instrSlotsC;
  logic [maxInstr-1:0]                  instrEnC;
  logic                                 overflowC;
  jumpSlot_t [maxJumps-1:0]             jumpSlotsC;
  logic [maxJumps-1:0]                  jumpEnC;
  logic                                 jumpOverflowC;

  // windows near the top end read zeros
  assign paddedBundle = {{(instrW-parcelW){1'b0}}, heldBundle};

  bundleCapture u_bundleCapture (
    .clk        (clk),
    .rstN       (rstN),
    .bundle     (bundle),
    .stopBits   (stopBits),
    .startOff   (startOff),
    .bundleReq  (bundleReq),
    .take       (take),
    .bundleAck  (bundleAck),
    .heldBundle (heldBundle),
    .heldStop   (heldStop),
    .heldOff    (heldOff),
    .full       (full)
  );

  boundaryScan u_boundaryScan (
    .heldStop  (heldStop),
    .heldOff   (heldOff),
    .isStart   (isStart),
    .len       (len),
    .malformed (scanMalformed)
  );

  for (genvar i = 0; i < numParcels; i++) begin : gParcel
    instrClassifier u_instrClassifier (
      .parcel (heldBundle[i*parcelW +: parcelW]),
      .cls    (cls[i])
    );

    assign instrEntry[i] = '{
      word: paddedBundle[i*parcelW +: instrW],
      len:  len[i],
      off:  offW'(i),
      cls:  cls[i]
    };

    // a jump whose instruction was dropped is dropped too
    assign jumpValid[i] = isStart[i] && cls[i][clsJump] && (int'(instrIdx[i]) < maxInstr);

    assign jumpEntry[i] = '{
      off:   offW'(i),
      disp:  heldBundle[i*parcelW+8 +: 8],
      slot:  instrIdx[i],
      indir: cls[i][clsIndir]
    };
  end

  slotCompactor #(
    .numSlots  (maxInstr),
    .payload_t (instrSlot_t)
  ) u_instrCompactor (
    .entryValid (isStart),
    .entry      (instrEntry),
    .slot       (instrSlotsC),
    .slotEn     (instrEnC),
    .excess     (overflowC),
    .slotIdx    (instrIdx)
  );

  slotCompactor #(
    .numSlots  (maxJumps),
    .payload_t (jumpSlot_t)
  ) u_jumpCompactor (
    .entryValid (jumpValid),
    .entry      (jumpEntry),
    .slot       (jumpSlotsC),
    .slotEn     (jumpEnC),
    .excess     (jumpOverflowC),
    .slotIdx    ()
  );

  resultStage #(
    .maxInstr (maxInstr),
    .maxJumps (maxJumps)
  ) u_resultStage (
    .clk            (clk),
    .rstN           (rstN),
    .full           (full),
    .instrSlotsIn   (instrSlotsC),
    .instrEnIn      (instrEnC),
    .jumpSlotsIn    (jumpSlotsC),
    .jumpEnIn       (jumpEnC),
    .overflowIn     (overflowC),
    .jumpOverflowIn (jumpOverflowC),
    .malformedIn    (scanMalformed),
    .outAck         (outAck),
    .take           (take),
    .outReq         (outReq),
    .instrSlots     (instrSlots),
    .instrEn        (instrEn),
    .jumpSlots      (jumpSlots),
    .jumpEn         (jumpEn),
    .overflow       (overflow),
    .jumpOverflow   (jumpOverflow),
    .malformed      (malformed)
  );

endmodule

`default_nettype wire

//--- instrClassifier.sv
// *********************************************************************
// instruction classifier
// class vector of one instruction from the low byte of its
// first parcel, zero-displacement jumps decode as ALU hints
// *********************************************************************
`timescale 1ns/1ps
`default_nettype none

module instrClassifier import predecodePkg::*; (
  input  logic [parcelW-1:0] parcel,
  output instrClass_t        cls
);

  logic [7:0] opcode;
  logic       hasDisp;

  assign opcode  = parcel[7:0];
  assign hasDisp = |parcel[parcelW-1:8];

  always_comb begin
    cls = '0;
    casez (opcode)
      8'b00??_????: cls[clsAlu]   = 1'b1;   // 0-63
      8'b010?_????: cls[clsShift] = 1'b1;   // 64-95
      8'b011?_????: cls[clsMul]   = 1'b1;   // 96-127
      8'b100?_????: cls[clsLoad]  = 1'b1;   // 128-159
      8'b101?_????: cls[clsStore] = 1'b1;   // 160-191
      8'b110?_????: begin
        // hint when the displacement byte is zero
        if (hasDisp)
          cls[clsJump] = 1'b1;
        else
          cls[clsAlu] = 1'b1;
      end
      8'b1110_????: begin
        cls[clsJump]  = 1'b1;
        cls[clsIndir] = 1'b1;
      end
      8'b1111_0???: cls[clsFpu] = 1'b1;
      default: begin
        // 248-255, fpu load
        cls[clsFpu]  = 1'b1;
        cls[clsLoad] = 1'b1;
      end
    endcase
  end

endmodule

`default_nettype wire

//--- predecodeChecker.sv
// *********************************************************************
// predecoder checker
// records accepted bundles, decodes them with a reference model
// and compares every result field when outReq rises
// *********************************************************************
`timescale 1ns/1ps
`default_nettype none

module predecodeChecker import predecodePkg::*; #(
  parameter int maxInstr = 8,
  parameter int maxJumps = 4
) (
  input  logic                      clk,
  input  logic                      rstN,
  input  logic [bundleW-1:0]        bundle,
  input  logic [numParcels-1:0]     stopBits,
  input  logic [offW-1:0]           startOff,
  input  logic                      bundleAck,
  input  logic                      outReq,
  input  logic                      outAck,
  input  instrSlot_t [maxInstr-1:0] instrSlots,
  input  logic [maxInstr-1:0]       instrEn,
  input  jumpSlot_t [maxJumps-1:0]  jumpSlots,
  input  logic [maxJumps-1:0]       jumpEn,
  input  logic                      overflow,
  input  logic                      jumpOverflow,
  input  logic                      malformed,
  output int                        errCount,
  output int                        resultCount
);

  logic [bundleW-1:0]    bundleQ[$];
  logic [numParcels-1:0] stopQ[$];
  logic [offW-1:0]       offQ[$];
  logic                  ackPrev    = 1'b0;
  logic                  reqPrev    = 1'b0;
  logic                  outAckPrev = 1'b0;
  int                    errs       = 0;
  int                    results    = 0;
  int                    captured   = 0;
  int                    consumed   = 0;
  int                    rstCycles  = 0;

  assign errCount    = errs;
  assign resultCount = results;

  task automatic compareField(input string name, input logic [instrW-1:0] expVal,
                              input logic [instrW-1:0] actVal);
    if (actVal !== expVal) begin
      $display("Error: result %0d %s expected %h got %h", results, name, expVal, actVal);
      errs++;
    end
  endtask

  // class ranges of the low opcode byte
  function automatic instrClass_t classOf(input logic [parcelW-1:0] p);
    instrClass_t c;
    int op;
    c  = '0;
    op = int'(p[7:0]);
    if (op < 64) c[clsAlu] = 1'b1;
    else if (op < 96) c[clsShift] = 1'b1;
    else if (op < 128) c[clsMul] = 1'b1;
    else if (op < 160) c[clsLoad] = 1'b1;
    else if (op < 192) c[clsStore] = 1'b1;
    else if (op < 224) begin
      if (p[15:8] == 8'h00)
        c[clsAlu] = 1'b1;   // hint
      else
        c[clsJump] = 1'b1;
    end else if (op < 240) begin
      c[clsJump]  = 1'b1;
      c[clsIndir] = 1'b1;
    end else if (op < 248) c[clsFpu] = 1'b1;
    else begin
      c[clsFpu]  = 1'b1;
      c[clsLoad] = 1'b1;
    end
    return c;
  endfunction

  task automatic checkResult(input logic [bundleW-1:0] b, input logic [numParcels-1:0] s,
                             input logic [offW-1:0] o);
    instrSlot_t          expI [maxInstr];
    jumpSlot_t           expJ [maxJumps];
    logic [maxInstr-1:0] expIEn;
    logic [maxJumps-1:0] expJEn;
    logic [instrW-1:0]   win;
    logic                expOvf, expJOvf, expMal, stopped;
    instrClass_t         c;
    int                  p, e, nI, nJ;

    expIEn  = '0;
    expJEn  = '0;
    expOvf  = 1'b0;
    expJOvf = 1'b0;
    expMal  = 1'b0;
    stopped = 1'b0;
    nI      = 0;
    nJ      = 0;
    p       = int'(o);
    while (p < numParcels && !stopped) begin
      e = p;
      while (e < numParcels && !s[e])
        e++;
      if (e == numParcels) begin
        expMal  = 1'b1;     // no stop after this start
        stopped = 1'b1;
      end else begin
        if (e - p + 1 > maxLen)
          expMal = 1'b1;
        else if (nI >= maxInstr)
          expOvf = 1'b1;
        else begin
          c   = classOf(b[p*parcelW +: parcelW]);
          win = '0;
          for (int k = 0; k < maxLen; k++)
            if (p + k < numParcels)
              win[k*parcelW +: parcelW] = b[(p+k)*parcelW +: parcelW];
          expI[nI].word = win;
          expI[nI].len  = lenW'(e - p + 1);
          expI[nI].off  = offW'(p);
          expI[nI].cls  = c;
          expIEn[nI]    = 1'b1;
          if (c[clsJump] && nJ >= maxJumps)
            expJOvf = 1'b1;
          else if (c[clsJump]) begin
            expJ[nJ].off   = offW'(p);
            expJ[nJ].disp  = b[p*parcelW+8 +: 8];
            expJ[nJ].slot  = offW'(nI);
            expJ[nJ].indir = c[clsIndir];
            expJEn[nJ]     = 1'b1;
            nJ++;
          end
          nI++;
        end
        p = e + 1;
      end
    end

    compareField("instrEn", instrW'(expIEn), instrW'(instrEn));
    compareField("jumpEn", instrW'(expJEn), instrW'(jumpEn));
    compareField("overflow", instrW'(expOvf), instrW'(overflow));
    compareField("jumpOverflow", instrW'(expJOvf), instrW'(jumpOverflow));
    compareField("malformed", instrW'(expMal), instrW'(malformed));
    for (int k = 0; k < maxInstr; k++) begin
      if (expIEn[k]) begin
        compareField($sformatf("instrSlots[%0d].word", k), expI[k].word, instrSlots[k].word);
        compareField($sformatf("instrSlots[%0d].len", k), instrW'(expI[k].len),
                     instrW'(instrSlots[k].len));
        compareField($sformatf("instrSlots[%0d].off", k), instrW'(expI[k].off),
                     instrW'(instrSlots[k].off));
        compareField($sformatf("instrSlots[%0d].cls", k), instrW'(expI[k].cls),
                     instrW'(instrSlots[k].cls));
      end
    end
    for (int k = 0; k < maxJumps; k++) begin
      if (expJEn[k])
        compareField($sformatf("jumpSlots[%0d]", k), instrW'(expJ[k]), instrW'(jumpSlots[k]));
    end
  endtask

  always @(posedge clk) begin
    if (!rstN) begin
      if (rstCycles > 1 && (bundleAck !== 1'b0 || outReq !== 1'b0 ||
                            instrEn !== '0 || jumpEn !== '0)) begin
        $display("reset did not clear bundleAck, outReq, instrEn and jumpEn");
        errs++;
      end
      rstCycles++;
    end else begin
      // ack rising means the bundle was latched, data still held
      if (bundleAck && !ackPrev) begin
        if (captured - consumed >= 2) begin
          $display("bundle %0d was accepted while capture and result stage were full",
                   captured);
          errs++;
        end
        bundleQ.push_back(bundle);
        stopQ.push_back(stopBits);
        offQ.push_back(startOff);
        captured++;
      end
      if (!outAck && outAckPrev)
        consumed++;            // result stage free again
      if (outReq && !reqPrev) begin
        if (bundleQ.size() == 0) begin
          $display("result %0d arrived with no bundle pending", results);
          errs++;
        end else
          checkResult(bundleQ.pop_front(), stopQ.pop_front(), offQ.pop_front());
        results++;
      end
    end
    ackPrev    = bundleAck;
    reqPrev    = outReq;
    outAckPrev = outAck;
  end

endmodule

`default_nettype wire

//--- predecodePkg.sv
// *********************************************************************
// predecoder shared definitions
// sizes, class bit positions and the slot payload types
// *********************************************************************
`default_nettype none

package predecodePkg;

  // bundle geometry
  localparam int parcelW    = 16;
  localparam int numParcels = 16;
  localparam int bundleW    = parcelW * numParcels;
  localparam int maxLen     = 4;                  // parcels per instruction
  localparam int instrW     = parcelW * maxLen;   // window of one instruction
  localparam int offW       = 4;
  localparam int lenW       = 3;

  // class vector, one bit per class
  localparam int classW   = 8;
  localparam int clsAlu   = 0;
  localparam int clsShift = 1;
  localparam int clsMul   = 2;
  localparam int clsLoad  = 3;
  localparam int clsStore = 4;
  localparam int clsJump  = 5;
  localparam int clsIndir = 6;
  localparam int clsFpu   = 7;

  typedef logic [classW-1:0] instrClass_t;

  typedef struct packed {
    logic [instrW-1:0] word;  // zero beyond parcel 15
    logic [lenW-1:0]   len;
    logic [offW-1:0]   off;
    instrClass_t       cls;
  } instrSlot_t;

  typedef struct packed {
    logic [offW-1:0] off;
    logic [7:0]      disp;   // upper byte of first parcel
    logic [offW-1:0] slot;   // instruction slot of this jump
    logic            indir;
  } jumpSlot_t;

endpackage

`default_nettype wire

//--- project.f
predecodePkg.sv
bundleCapture.sv
boundaryScan.sv
instrClassifier.sv
slotCompactor.sv
resultStage.sv
bundlePredecode.sv
predecodeChecker.sv
tbBundlePredecode.sv

//--- resultStage.sv
// *********************************************************************
// result stage
// registers one predecode result and presents it under a
// four-phase outReq/outAck handshake
// *********************************************************************
`timescale 1ns/1ps
`default_nettype none

module resultStage import predecodePkg::*; #(
  parameter int maxInstr = 8,
  parameter int maxJumps = 4
) (
  input  logic                        clk,
  input  logic                        rstN,
  input  logic                        full,
  input  instrSlot_t [maxInstr-1:0]   instrSlotsIn,
  input  logic [maxInstr-1:0]         instrEnIn,
  input  jumpSlot_t [maxJumps-1:0]    jumpSlotsIn,
  input  logic [maxJumps-1:0]         jumpEnIn,
  input  logic                        overflowIn,
  input  logic                        jumpOverflowIn,
  input  logic                        malformedIn,
  input  logic                        outAck,
  output logic                        take,
  output logic                        outReq,
  output instrSlot_t [maxInstr-1:0]   instrSlots,
  output logic [maxInstr-1:0]         instrEn,
  output jumpSlot_t [maxJumps-1:0]    jumpSlots,
  output logic [maxJumps-1:0]         jumpEn,
  output logic                        overflow,
  output logic                        jumpOverflow,
  output logic                        malformed
);

  typedef enum logic [1:0] {
    sEmpty,
    sPresent,
    sWaitLow
  } state_t;

  state_t state;

  assign take   = (state == sEmpty) && full;
  assign outReq = (state == sPresent);

  always_ff @(posedge clk) begin
    if (!rstN) begin
      state        <= sEmpty;
      instrEn      <= '0;
      jumpEn       <= '0;
      overflow     <= 1'b0;
      jumpOverflow <= 1'b0;
      malformed    <= 1'b0;
    end else begin
      case (state)
        sEmpty: begin
          if (full) begin
            state        <= sPresent;
            instrEn      <= instrEnIn;
            jumpEn       <= jumpEnIn;
            overflow     <= overflowIn;
            jumpOverflow <= jumpOverflowIn;
            malformed    <= malformedIn;
          end
        end
        sPresent: if (outAck) state <= sWaitLow;
        default:  if (!outAck) state <= sEmpty;   // ack returned to zero
      endcase
    end
  end

  // slot payload
  always_ff @(posedge clk) begin
    if (take) begin
      instrSlots <= instrSlotsIn;
      jumpSlots  <= jumpSlotsIn;
    end
  end

endmodule

`default_nettype wire

//--- slotCompactor.sv
// *********************************************************************
// slot compactor
// packs flagged per-parcel entries into consecutive slots, in
// parcel order, and reports entries that found no slot
// *********************************************************************
`timescale 1ns/1ps
`default_nettype none

module slotCompactor import predecodePkg::*; #(
  parameter int  numSlots  = 8,
  parameter type payload_t = logic [7:0]
) (
  input  logic [numParcels-1:0]           entryValid,
  input  payload_t [numParcels-1:0]       entry,
  output payload_t [numSlots-1:0]         slot,
  output logic [numSlots-1:0]             slotEn,
  output logic                            excess,
  output logic [numParcels-1:0][offW-1:0] slotIdx
);

  always_comb begin
    int cnt;

    cnt     = 0;
    slot    = '0;
    slotEn  = '0;
    excess  = 1'b0;
    for (int i = 0; i < numParcels; i++) begin
      slotIdx[i] = offW'(cnt);   // valid entries ahead of this one
      if (entryValid[i]) begin
        if (cnt < numSlots) begin
          slot[cnt]   = entry[i];
          slotEn[cnt] = 1'b1;
        end else begin
          excess = 1'b1;
        end
        cnt++;
      end
    end
  end

endmodule

`default_nettype wire

//--- tbBundlePredecode.sv
// *********************************************************************
// bundle predecoder testbench
// random bundles through both four-phase handshakes, results
// compared by the checker
// *********************************************************************
`timescale 1ns/1ps
`default_nettype none

module tbBundlePredecode import predecodePkg::*; ();

  localparam int maxInstr      = 8;
  localparam int maxJumps      = 4;
  localparam int resetCycles   = 10;
  localparam int nHandshake    = 12;
  localparam int nBoundary     = 40;
  localparam int nClass        = 64;
  localparam int nOverflow     = 20;
  localparam int nMalformed    = 30;
  localparam int nBackPressure = 9;
  localparam int totalBundles  = nHandshake + nBoundary + nClass + nOverflow + nMalformed +
                                 nBackPressure;
  localparam int cycleLimit    = totalBundles * 20 + resetCycles;

  logic                      clk;
  logic                      rstN;
  logic [bundleW-1:0]        bundle;
  logic [numParcels-1:0]     stopBits;
  logic [offW-1:0]           startOff;
  logic                      bundleReq;
  logic                      outAck;
  logic                      bundleAck;
  logic                      outReq;
  instrSlot_t [maxInstr-1:0] instrSlots;
  logic [maxInstr-1:0]       instrEn;
  jumpSlot_t [maxJumps-1:0]  jumpSlots;
  logic [maxJumps-1:0]       jumpEn;
  logic                      overflow;
  logic                      jumpOverflow;
  logic                      malformed;
  int                        errCount;
  int                        resultCount;
  logic                      holdAck;
  logic [31:0]               rngState = 32'd79;
  int                        sent     = 0;
  int                        cycles   = 0;
  int                        errStart = 0;
  int                        resStart = 0;

  bundlePredecode #(.maxInstr(maxInstr), .maxJumps(maxJumps)) u_bundlePredecode (
    .clk(clk), .rstN(rstN), .bundle(bundle), .stopBits(stopBits), .startOff(startOff),
    .bundleReq(bundleReq), .outAck(outAck), .bundleAck(bundleAck), .outReq(outReq),
    .instrSlots(instrSlots), .instrEn(instrEn), .jumpSlots(jumpSlots), .jumpEn(jumpEn),
    .overflow(overflow), .jumpOverflow(jumpOverflow), .malformed(malformed)
  );

  predecodeChecker #(.maxInstr(maxInstr), .maxJumps(maxJumps)) u_predecodeChecker (
    .clk(clk), .rstN(rstN), .bundle(bundle), .stopBits(stopBits), .startOff(startOff),
    .bundleAck(bundleAck), .outReq(outReq), .outAck(outAck), .instrSlots(instrSlots),
    .instrEn(instrEn), .jumpSlots(jumpSlots), .jumpEn(jumpEn), .overflow(overflow),
    .jumpOverflow(jumpOverflow), .malformed(malformed), .errCount(errCount),
    .resultCount(resultCount)
  );

  // lcg, upper half is the usable part
  function automatic logic [15:0] nextRand();
    rngState = rngState * 32'd1664525 + 32'd1013904223;
    return rngState[31:16];
  endfunction

  function automatic logic [bundleW-1:0] randomParcels();
    logic [bundleW-1:0] v;
    for (int k = 0; k < numParcels; k++)
      v[k*parcelW +: parcelW] = nextRand();
    return v;
  endfunction

  // stop vector of runs 1..longest long from off, junk below off
  function automatic logic [numParcels-1:0] makeStops(input int off, input int longest);
    logic [numParcels-1:0] s;
    int p;
    int e;
    s = nextRand();
    for (int i = off; i < numParcels; i++)
      s[i] = 1'b0;
    p = off;
    while (p < numParcels) begin
      e = p + int'(nextRand() % 16'(longest));
      if (e > numParcels - 1)
        e = numParcels - 1;
      s[e] = 1'b1;
      p = e + 1;
    end
    return s;
  endfunction

  // input side four-phase handshake, entered and left just after an edge
  task automatic sendBundle(input logic [bundleW-1:0] b, input logic [numParcels-1:0] s,
                            input logic [offW-1:0] o);
    bundle    = b;
    stopBits  = s;
    startOff  = o;
    bundleReq = 1'b1;
    @(posedge clk);
    while (!bundleAck) @(posedge clk);
    #1 bundleReq = 1'b0;
    @(posedge clk);
    while (bundleAck) @(posedge clk);
    #1;
    sent++;
  endtask

  // every bundle sent so far has shown its result
  task automatic waitResults();
    do @(negedge clk); while (resultCount != sent);
    @(posedge clk);
    #1;
  endtask

  task automatic finishTest(input string name);
    waitResults();
    $display("test %-14s %0d results, %0d errors", name, resultCount - resStart,
             errCount - errStart);
    errStart = errCount;
    resStart = resultCount;
  endtask

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  always @(posedge clk) begin
    cycles++;
    if (cycles > cycleLimit) begin
      $display("timeout after %0d cycles, %0d of %0d results seen", cycles, resultCount, sent);
      $display("Simulation FAILED");
      $finish;
    end
  end

  // consumer, random ack delay unless held off
  initial begin
    int d;
    forever begin
      @(posedge clk);
      if (rstN && outReq && !holdAck) begin
        d = int'(nextRand() % 16'd4);
        repeat (d) @(posedge clk);
        #1 outAck = 1'b1;
        @(posedge clk);
        while (outReq) @(posedge clk);
        #1 outAck = 1'b0;
      end
    end
  end

  initial begin
    logic [bundleW-1:0]    b;
    logic [numParcels-1:0] s;
    logic [offW-1:0]       o;
    logic [15:0]           r;

    bundle    = '0;
    stopBits  = '0;
    startOff  = '0;
    bundleReq = 1'b0;
    outAck    = 1'b0;
    holdAck   = 1'b0;
    rstN      = 1'b0;
    repeat (resetCycles) @(posedge clk);
    #1 rstN = 1'b1;
    @(posedge clk);
    #1;

    for (int n = 0; n < nHandshake + nBoundary; n++) begin
      b = randomParcels();
      s = makeStops(0, maxLen);
      sendBundle(b, s, '0);
      if (n == nHandshake - 1)
        finishTest("handshake");
    end
    finishTest("boundaries");

    // every opcode byte, zero then nonzero upper byte
    for (int pass = 0; pass < 2; pass++) begin
      for (int grp = 0; grp < nClass / 2; grp++) begin
        b = randomParcels();
        for (int k = 0; k < 8; k++) begin
          r = nextRand();
          b[2*k*parcelW +: parcelW] = {(pass == 0) ? 8'h00 : (r[7:0] | 8'h01), 8'(grp*8 + k)};
        end
        sendBundle(b, 16'hAAAA, '0);
      end
    end
    finishTest("classification");

    for (int n = 0; n < nOverflow; n++) begin
      b = randomParcels();
      s = makeStops(0, (n % 2) + 1);
      if (n >= nOverflow / 2) begin
        for (int k = 0; k < numParcels; k++) begin
          r = nextRand();
          b[k*parcelW +: parcelW] = {r[15:8] | 8'h01, 8'hC0 + 8'(r[7:0] % 8'd48)};
        end
      end
      sendBundle(b, s, '0);
    end
    finishTest("overflow");

    for (int n = 0; n < nMalformed; n++) begin
      b = randomParcels();
      o = 4'(nextRand());
      s = makeStops(int'(o), 6);
      if (n % 3 == 0)
        s[numParcels-1] = 1'b0;   // tail without stop
      sendBundle(b, s, o);
    end
    finishTest("malformed");

    // third bundle must wait until the first result is acked
    for (int n = 0; n < nBackPressure / 3; n++) begin
      waitResults();   // last round's results already with the consumer
      holdAck = 1'b1;
      for (int k = 0; k < 2; k++) begin
        b = randomParcels();
        s = makeStops(0, maxLen);
        sendBundle(b, s, '0);
      end
      b = randomParcels();
      s = makeStops(0, maxLen);
      fork
        sendBundle(b, s, '0);
        begin
          repeat (8) @(posedge clk);
          #1 holdAck = 1'b0;
        end
      join
    end
    finishTest("backpressure");

    $display("%0d bundles sent, %0d results checked, %0d errors", sent, resultCount, errCount);
    if (errCount == 0)
      $display("Simulation PASSED");
    else
      $display("Simulation FAILED");
    $finish;
  end

endmodule

`default_nettype wire
